/* hdl/l1b_config.svh */
`ifndef L1B_CONFIG_SVH
`define L1B_CONFIG_SVH

// channel count, halves split the texture row
`define L1B_BANK_CH 4

// rows held by each channel
`define L1B_RAM_DEPTH 64

// byte width
`define L1B_WORD_WID 8

// bytes per row
`define L1B_LB_CH 16

// one row, 128 bits by default
`define L1B_ROW_WID (`L1B_WORD_WID * `L1B_LB_CH)

// compute word address covers four 32-bit words per row
`define L1B_WORD_ADDR_WID $clog2(`L1B_RAM_DEPTH * 4)

// texture row address
`define L1B_ROW_ADDR_WID $clog2(`L1B_RAM_DEPTH)

`endif

/* hdl/l1b_pkg.sv */
`default_nettype none

`include "l1b_config.svh"

package l1b_pkg;

   // active client of the bank
   typedef enum logic {
      MODE_TCACHE = 1'b0,
      MODE_CUBANK = 1'b1
   } l1b_mode_e;

   // texture side FSM
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_READ = 2'd1, // read issued, data arrives next edge
      ST_RESP = 2'd2  // response held until taken
   } ctrl_state_e;

   // compute-bank word access, one per channel
   typedef struct packed {
      logic                             we;
      logic [3:0]                       be;
      logic [31:0]                      wdata;
      logic [`L1B_WORD_ADDR_WID-1:0]    addr;  // row * 4 + lane
   } cu_req_t;

   // texture-cache row access, whole bank
   typedef struct packed {
      logic [`L1B_BANK_CH-1:0]          cs;
      logic                             we;
      logic [`L1B_ROW_ADDR_WID-1:0]     addr;
      logic [2*`L1B_ROW_WID-1:0]        wdata;   // lower half to lower channels
      logic [2*`L1B_LB_CH-1:0]          bitmask; // one bit per byte
   } tc_req_t;

   // one channel's slice of a texture access
   typedef struct packed {
      logic                             en;
      logic                             we;
      logic [`L1B_ROW_ADDR_WID-1:0]     addr;
      logic [`L1B_ROW_WID-1:0]          wdata;
      logic [`L1B_LB_CH-1:0]            bitmask;
   } tc_ch_req_t;

   typedef struct packed {
      logic [`L1B_BANK_CH-1:0]                     rvalid; // copy of the request cs
      logic [`L1B_BANK_CH-1:0][`L1B_ROW_WID-1:0]   rdata;
   } tc_rsp_t;

endpackage

`default_nettype wire

/* hdl/l1b_ram.sv */
`default_nettype none

`include "l1b_config.svh"

module l1b_ram (
   input  wire logic                           clk,
   input  wire logic                           en,
   input  wire logic                           we,
   input  wire logic [`L1B_ROW_ADDR_WID-1:0]   addr,
   input  wire logic [`L1B_ROW_WID-1:0]        wdata,
   input  wire logic [`L1B_LB_CH-1:0]          wbe,
   output logic      [`L1B_ROW_WID-1:0]        rdata
);

   localparam int BW = `L1B_WORD_WID;

   logic [`L1B_ROW_WID-1:0] mem [`L1B_RAM_DEPTH];

   // byte lanes written independently
   always_ff @(posedge clk) begin
      if (en && we) begin
         for (int b = 0; b < `L1B_LB_CH; b++) begin
            if (wbe[b]) begin
               mem[addr][b*BW +: BW] <= wdata[b*BW +: BW];
            end
         end
      end
   end

   // one cycle read latency
   // rdata only moves on a read, so it holds between accesses
   always_ff @(posedge clk) begin
      if (en && !we) begin
         rdata <= mem[addr];
      end
   end

endmodule

`default_nettype wire

/* hdl/l1b_ch.sv */
`default_nettype none

`include "l1b_config.svh"

module l1b_ch (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire logic                       cu_en,        // high in compute-bank mode
   // compute-bank word port
   input  wire logic                       cu_req_valid,
   input  wire l1b_pkg::cu_req_t           cu_req,
   output logic                            cu_gnt,
   output logic                            cu_rvalid,
   output logic [31:0]                     cu_rdata,
   // texture row port
   input  wire l1b_pkg::tc_ch_req_t        tc_ch,
   output logic [`L1B_ROW_WID-1:0]         row_rdata
);

   localparam int LANES    = `L1B_LB_CH / 4;
   localparam int LANE_WID = $clog2(LANES);

   logic [LANE_WID-1:0]              cu_lane;
   logic [LANE_WID-1:0]              rd_lane;
   logic                             cu_rd;
   logic                             rd_pend;

   logic                             ram_en;
   logic                             ram_we;
   logic [`L1B_ROW_ADDR_WID-1:0]     ram_addr;
   logic [`L1B_ROW_WID-1:0]          ram_wdata;
   logic [`L1B_LB_CH-1:0]            ram_wbe;
   logic [`L1B_ROW_WID-1:0]          ram_rdata;

   // grant only while the bank is owned by the compute side
   assign cu_gnt = cu_req_valid & cu_en;
   assign cu_rd  = cu_gnt & ~cu_req.we;

   assign cu_lane = cu_req.addr[LANE_WID-1:0]; // low bits pick the word in the row

   // storage port mux
   always_comb begin
      if (cu_en) begin
         ram_en    = cu_gnt;
         ram_we    = cu_req.we;
         ram_addr  = cu_req.addr[`L1B_WORD_ADDR_WID-1:LANE_WID];
         ram_wdata = {LANES{cu_req.wdata}}; // word copied to every lane
         ram_wbe   = '0;
         ram_wbe[cu_lane*4 +: 4] = cu_req.be;
      end else begin
         ram_en    = tc_ch.en;
         ram_we    = tc_ch.we;
         ram_addr  = tc_ch.addr;
         ram_wdata = tc_ch.wdata;
         ram_wbe   = tc_ch.bitmask;
      end
   end

   l1b_ram ram_i (
      .clk   (clk),
      .en    (ram_en),
      .we    (ram_we),
      .addr  (ram_addr),
      .wdata (ram_wdata),
      .wbe   (ram_wbe),
      .rdata (ram_rdata)
   );

   // pending compute read, answered next cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= cu_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (cu_rd) begin
         rd_lane <= cu_lane; // remembered for the word select
      end
   end

   assign cu_rvalid = rd_pend;
   assign cu_rdata  = ram_rdata[rd_lane*32 +: 32];

   // whole row back to the controller
   assign row_rdata = ram_rdata;

endmodule

`default_nettype wire

/* hdl/l1b_ctrl.sv */
`default_nettype none

`include "l1b_config.svh"

module l1b_ctrl (
   input  wire logic                                         clk,
   input  wire logic                                         reset,
   input  wire l1b_pkg::l1b_mode_e                           gpu_mode,
   // texture request
   input  wire logic                                         tc_req_valid,
   input  wire l1b_pkg::tc_req_t                             tc_req,
   output logic                                              tc_req_ready,
   // texture response
   output logic                                              tc_rsp_valid,
   output l1b_pkg::tc_rsp_t                                  tc_rsp,
   input  wire logic                                         tc_rsp_ready,
   // channel side
   output logic                                              cu_en,
   output l1b_pkg::tc_ch_req_t [`L1B_BANK_CH-1:0]            tc_ch,
   input  wire logic [`L1B_BANK_CH-1:0][`L1B_ROW_WID-1:0]    row_rdata
);

   import l1b_pkg::*;

   localparam int HALF = `L1B_BANK_CH / 2;

   ctrl_state_e               state;
   ctrl_state_e               state_nxt;
   l1b_mode_e                 mode;
   logic                      tc_accept;
   logic [`L1B_BANK_CH-1:0]   cs_q;
   tc_rsp_t                   rsp_q;

   assign tc_req_ready = (state == ST_IDLE) && (mode == MODE_TCACHE);
   assign tc_accept    = tc_req_valid & tc_req_ready;
   assign tc_rsp_valid = (state == ST_RESP);
   assign tc_rsp       = rsp_q;
   assign cu_en        = (mode == MODE_CUBANK);

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: if (tc_accept && !tc_req.we) state_nxt = ST_READ; // writes need no response
         ST_READ: state_nxt = ST_RESP;
         ST_RESP: if (tc_rsp_ready) state_nxt = ST_IDLE;
         default: state_nxt = ST_IDLE;
      endcase
   end

   // mode only follows gpu_mode with nothing in flight
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
         mode  <= MODE_TCACHE;
      end else begin
         state <= state_nxt;
         if (state == ST_IDLE) begin
            mode <= gpu_mode;
         end
      end
   end

   // broadcast, each half of the bank takes its half of the row
   always_comb begin
      for (int i = 0; i < `L1B_BANK_CH; i++) begin
         tc_ch[i].en      = tc_accept & tc_req.cs[i];
         tc_ch[i].we      = tc_req.we;
         tc_ch[i].addr    = tc_req.addr;
         tc_ch[i].wdata   = tc_req.wdata[(i / HALF)*`L1B_ROW_WID +: `L1B_ROW_WID];
         tc_ch[i].bitmask = tc_req.bitmask[(i / HALF)*`L1B_LB_CH +: `L1B_LB_CH];
      end
   end

   always_ff @(posedge clk) begin
      if (tc_accept) begin
         cs_q <= tc_req.cs;
      end
      // capture edge, unselected channels report zero
      if (state == ST_READ) begin
         rsp_q.rvalid <= cs_q;
         for (int i = 0; i < `L1B_BANK_CH; i++) begin
            rsp_q.rdata[i] <= cs_q[i] ? row_rdata[i] : '0;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/l1b_bank.sv */
`default_nettype none

`include "l1b_config.svh"

module l1b_bank (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire l1b_pkg::l1b_mode_e                     gpu_mode,    // wanted client
   // texture-cache port
   input  wire logic                                   tc_req_valid,
   input  wire l1b_pkg::tc_req_t                       tc_req,
   output logic                                        tc_req_ready,
   output logic                                        tc_rsp_valid,
   output l1b_pkg::tc_rsp_t                            tc_rsp,
   input  wire logic                                   tc_rsp_ready,
   // compute-bank ports, one per channel
   input  wire logic [`L1B_BANK_CH-1:0]                cu_req_valid,
   input  wire l1b_pkg::cu_req_t [`L1B_BANK_CH-1:0]    cu_req,
   output logic [`L1B_BANK_CH-1:0]                     cu_gnt,
   output logic [`L1B_BANK_CH-1:0]                     cu_rvalid,
   output logic [`L1B_BANK_CH-1:0][31:0]               cu_rdata
);

   import l1b_pkg::*;

   logic                                        cu_en;
   tc_ch_req_t [`L1B_BANK_CH-1:0]               tc_ch;
   logic [`L1B_BANK_CH-1:0][`L1B_ROW_WID-1:0]   row_rdata;

   l1b_ctrl ctrl_i (
      .clk          (clk),
      .reset        (reset),
      .gpu_mode     (gpu_mode),
      .tc_req_valid (tc_req_valid),
      .tc_req       (tc_req),
      .tc_req_ready (tc_req_ready),
      .tc_rsp_valid (tc_rsp_valid),
      .tc_rsp       (tc_rsp),
      .tc_rsp_ready (tc_rsp_ready),
      .cu_en        (cu_en),
      .tc_ch        (tc_ch),
      .row_rdata    (row_rdata)
   );

   // storage channels
   for (genvar g = 0; g < `L1B_BANK_CH; g++) begin : g_ch
      l1b_ch ch_i (
         .clk          (clk),
         .reset        (reset),
         .cu_en        (cu_en),
         .cu_req_valid (cu_req_valid[g]),
         .cu_req       (cu_req[g]),
         .cu_gnt       (cu_gnt[g]),
         .cu_rvalid    (cu_rvalid[g]),
         .cu_rdata     (cu_rdata[g]),
         .tc_ch        (tc_ch[g]),
         .row_rdata    (row_rdata[g])
      );
   end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`default_nettype none

module tb_clock (
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
   end

   always #5 clk = ~clk; // 10 ns period

endmodule

`default_nettype wire

/* bench/l1b_bank_tb.sv */
`default_nettype none

`include "l1b_config.svh"

module l1b_bank_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import l1b_pkg::*;

   localparam int CH      = `L1B_BANK_CH;
   localparam int DEPTH   = `L1B_RAM_DEPTH;
   localparam int NB      = `L1B_LB_CH;
   localparam int ROW     = `L1B_ROW_WID;
   localparam int WA      = `L1B_WORD_ADDR_WID;
   localparam int RA      = `L1B_ROW_ADDR_WID;
   localparam int TIMEOUT = 50;

   logic                 clk;
   logic                 reset;
   l1b_mode_e            gpu_mode;
   logic                 tc_req_valid;
   tc_req_t              tc_req;
   logic                 tc_req_ready;
   logic                 tc_rsp_valid;
   tc_rsp_t              tc_rsp;
   logic                 tc_rsp_ready;
   logic [CH-1:0]        cu_req_valid;
   cu_req_t [CH-1:0]     cu_req;
   logic [CH-1:0]        cu_gnt;
   logic [CH-1:0]        cu_rvalid;
   logic [CH-1:0][31:0]  cu_rdata;

   logic [7:0] model [CH][DEPTH][NB]; // byte image of every channel
   integer     seed;
   int         errors;
   int         checks;

   tb_clock clk_i (.clk(clk));

   l1b_bank dut_i (
      .clk          (clk),
      .reset        (reset),
      .gpu_mode     (gpu_mode),
      .tc_req_valid (tc_req_valid),
      .tc_req       (tc_req),
      .tc_req_ready (tc_req_ready),
      .tc_rsp_valid (tc_rsp_valid),
      .tc_rsp       (tc_rsp),
      .tc_rsp_ready (tc_rsp_ready),
      .cu_req_valid (cu_req_valid),
      .cu_req       (cu_req),
      .cu_gnt       (cu_gnt),
      .cu_rvalid    (cu_rvalid),
      .cu_rdata     (cu_rdata)
   );

   task automatic report_and_finish();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      errors++;
      $display("timeout at %0t while waiting for %s", $time, what);
      report_and_finish();
   endtask

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_rsp(input string what, input tc_rsp_t got, input tc_rsp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s rvalid %b expected %b", $time, what,
                  got.rvalid, exp.rvalid);
         for (int i = 0; i < CH; i++) begin
            $display("   ch%0d got %h expected %h", i, got.rdata[i], exp.rdata[i]);
         end
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #1; // drive point after the edge
   endtask

   function automatic logic [ROW-1:0] rand_row();
      logic [ROW-1:0] r;
      for (int i = 0; i < ROW / 32; i++) begin
         r[i*32 +: 32] = $random(seed);
      end
      return r;
   endfunction

   function automatic logic [ROW-1:0] model_row(input int ch, input logic [RA-1:0] row);
      logic [ROW-1:0] r;
      for (int b = 0; b < NB; b++) begin
         r[b*8 +: 8] = model[ch][row][b];
      end
      return r;
   endfunction

   function automatic logic [31:0] model_word(input int ch, input logic [WA-1:0] addr);
      logic [31:0] w;
      for (int k = 0; k < 4; k++) begin
         w[k*8 +: 8] = model[ch][addr / 4][(addr % 4) * 4 + k];
      end
      return w;
   endfunction

   function automatic void model_cu_write(input int ch, input cu_req_t r);
      for (int k = 0; k < 4; k++) begin
         if (r.be[k]) model[ch][r.addr / 4][(r.addr % 4) * 4 + k] = r.wdata[k*8 +: 8];
      end
   endfunction

   // lower channels take the lower half of the texture row
   function automatic void model_tc_write(input tc_req_t r);
      int h;
      for (int ch = 0; ch < CH; ch++) begin
         h = ch / (CH / 2);
         if (r.cs[ch]) begin
            for (int b = 0; b < NB; b++) begin
               if (r.bitmask[h*NB + b]) model[ch][r.addr][b] = r.wdata[(h*NB + b)*8 +: 8];
            end
         end
      end
   endfunction

   function automatic tc_rsp_t expected_rsp(input tc_req_t r);
      tc_rsp_t e;
      e.rvalid = r.cs;
      for (int ch = 0; ch < CH; ch++) begin
         e.rdata[ch] = r.cs[ch] ? model_row(ch, r.addr) : '0;
      end
      return e;
   endfunction

   task automatic set_mode(input l1b_mode_e m);
      gpu_mode = m;
      step_cycle();
      step_cycle();
   endtask

   // returns just after the edge that accepts the request
   task automatic tc_send(input tc_req_t r);
      int t;
      t = 0;
      tc_req       = r;
      tc_req_valid = 1'b1;
      #1;
      while (!tc_req_ready) begin
         if (t == TIMEOUT) timeout_abort("tc_req_ready");
         step_cycle();
         #1;
         t++;
      end
      step_cycle();
      tc_req_valid = 1'b0;
      if (r.we) model_tc_write(r);
   endtask

   task automatic wait_rsp(output int lat);
      lat = 0;
      while (!tc_rsp_valid) begin
         if (lat == TIMEOUT) timeout_abort("tc_rsp_valid");
         step_cycle();
         lat++;
      end
   endtask

   task automatic take_rsp();
      tc_rsp_ready = 1'b1;
      step_cycle();
      tc_rsp_ready = 1'b0;
   endtask

   task automatic tc_read_check(input tc_req_t r, input string what);
      int lat;
      tc_send(r);
      wait_rsp(lat);
      check_word({what, " latency"}, lat, 1);
      check_rsp(what, tc_rsp, expected_rsp(r));
      take_rsp();
   endtask

   task automatic cu_access(input int ch, input cu_req_t r);
      int t;
      t = 0;
      cu_req[ch]       = r;
      cu_req_valid[ch] = 1'b1;
      #1;
      while (!cu_gnt[ch]) begin
         if (t == TIMEOUT) timeout_abort("cu_gnt");
         step_cycle();
         #1;
         t++;
      end
      step_cycle(); // grant edge
      cu_req_valid[ch] = 1'b0;
      if (r.we) begin
         model_cu_write(ch, r);
         check_flag("cu_rvalid after write", cu_rvalid[ch], 1'b0);
      end else begin
         check_flag("cu_rvalid after read", cu_rvalid[ch], 1'b1);
         check_word("cu_rdata", cu_rdata[ch], model_word(ch, r.addr));
      end
   endtask

   task automatic fill_all_rows();
      tc_req_t r;
      for (int row = 0; row < DEPTH; row++) begin
         r.cs      = '1;
         r.we      = 1'b1;
         r.addr    = RA'(row);
         r.wdata   = {rand_row(), rand_row()};
         r.bitmask = '1;
         tc_send(r);
      end
   endtask

   task automatic test_cu_lanes();
      cu_req_t r;
      for (int ch = 0; ch < CH; ch++) begin
         for (int lane = 0; lane < 4; lane++) begin
            r.we    = 1'b1;
            r.be    = 4'b0101 << (lane % 2); // partial enables
            r.wdata = $random(seed);
            r.addr  = WA'(5 * 4 + lane);
            cu_access(ch, r);
         end
         for (int lane = 0; lane < 4; lane++) begin
            r.we   = 1'b0;
            r.addr = WA'(5 * 4 + lane);
            cu_access(ch, r);
         end
      end
   endtask

   task automatic test_tc_row();
      tc_req_t r;
      r.cs      = 4'b1001; // one channel from each half
      r.we      = 1'b1;
      r.addr    = 9;
      r.wdata   = {rand_row(), rand_row()};
      r.bitmask = 32'h8421_0f03;
      tc_send(r);
      r.we = 1'b0;
      tc_read_check(r, "texture read");
      r.cs = '1;
      tc_read_check(r, "texture read all");
   endtask

   task automatic test_cross_mode();
      tc_req_t r;
      cu_req_t c;
      r.cs      = '1;
      r.we      = 1'b1;
      r.addr    = 17;
      r.wdata   = {rand_row(), rand_row()};
      r.bitmask = '1;
      tc_send(r);
      set_mode(MODE_CUBANK);
      for (int ch = 0; ch < CH; ch++) begin
         for (int lane = 0; lane < 4; lane++) begin
            c.we    = 1'b0;
            c.be    = '0;
            c.wdata = '0;
            c.addr  = WA'(17 * 4 + lane);
            cu_access(ch, c);
         end
      end
      set_mode(MODE_TCACHE);
   endtask

   task automatic test_backpressure();
      tc_req_t r;
      tc_req_t other;
      tc_rsp_t held;
      int      lat;
      r.cs       = 4'b0110;
      r.we       = 1'b0;
      r.addr     = 9;
      r.wdata    = '0;
      r.bitmask  = '0;
      other      = r;
      other.cs   = '1;
      other.addr = 17;
      tc_send(r);
      wait_rsp(lat);
      held = tc_rsp;
      check_rsp("held response", held, expected_rsp(r));
      tc_req       = other; // offered while the response is held
      tc_req_valid = 1'b1;
      repeat (6) begin
         step_cycle();
         check_flag("tc_rsp_valid under stall", tc_rsp_valid, 1'b1);
         check_flag("tc_req_ready under stall", tc_req_ready, 1'b0);
         check_rsp("stable response", tc_rsp, held);
      end
      tc_req_valid = 1'b0;
      take_rsp();
      check_flag("tc_rsp_valid after take", tc_rsp_valid, 1'b0);
      check_flag("tc_req_ready after take", tc_req_ready, 1'b1);
   endtask

   task automatic test_mode_gating();
      tc_req_t r;
      int      lat;
      cu_req[0].we     = 1'b0;
      cu_req[0].be     = '0;
      cu_req[0].addr   = '0;
      cu_req[0].wdata  = '0;
      cu_req_valid[0]  = 1'b1;
      #1;
      check_flag("cu_gnt in texture mode", cu_gnt[0], 1'b0);
      r.cs      = '1;
      r.we      = 1'b0;
      r.addr    = 3;
      r.wdata   = '0;
      r.bitmask = '0;
      tc_send(r);
      wait_rsp(lat);
      gpu_mode = MODE_CUBANK; // asked while a response waits
      repeat (4) begin
         step_cycle();
         check_flag("cu_gnt while response pending", cu_gnt[0], 1'b0);
      end
      take_rsp();
      check_flag("cu_gnt right after take", cu_gnt[0], 1'b0);
      step_cycle();
      check_flag("cu_gnt after mode change", cu_gnt[0], 1'b1);
      cu_req_valid[0] = 1'b0;
      tc_req_valid    = 1'b1;
      #1;
      check_flag("tc_req_ready in compute mode", tc_req_ready, 1'b0);
      tc_req_valid = 1'b0;
      step_cycle();
   endtask

   task automatic test_random_cu();
      cu_req_t c;
      logic    rd;
      for (int n = 0; n < 200; n++) begin
         for (int ch = 0; ch < CH; ch++) begin
            c.we    = 1'($random(seed));
            c.be    = 4'($random(seed));
            c.wdata = $random(seed);
            c.addr  = WA'($random(seed));
            cu_req[ch]       = c;
            cu_req_valid[ch] = 1'($random(seed));
         end
         step_cycle();
         // a granted read shows up right after its grant edge
         for (int ch = 0; ch < CH; ch++) begin
            rd = cu_req_valid[ch] && !cu_req[ch].we;
            check_flag("random cu_rvalid", cu_rvalid[ch], rd);
            if (rd) begin
               check_word("random cu_rdata", cu_rdata[ch], model_word(ch, cu_req[ch].addr));
            end else if (cu_req_valid[ch]) begin
               model_cu_write(ch, cu_req[ch]);
            end
         end
      end
      cu_req_valid = '0;
      step_cycle();
      check_flag("cu_rvalid after traffic", |cu_rvalid, 1'b0);
   endtask

   initial begin
      seed         = 62;
      errors       = 0;
      checks       = 0;
      reset        = 1'b1;
      gpu_mode     = MODE_TCACHE;
      tc_req_valid = 1'b0;
      tc_req       = '0;
      tc_rsp_ready = 1'b0;
      cu_req_valid = '0;
      cu_req       = '0;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      check_flag("tc_rsp_valid after reset", tc_rsp_valid, 1'b0);
      check_flag("tc_req_ready after reset", tc_req_ready, 1'b1);
      check_flag("cu_rvalid after reset", |cu_rvalid, 1'b0);
      fill_all_rows();
      test_tc_row();
      test_backpressure();
      test_cross_mode();
      test_mode_gating(); // leaves the bank in compute mode
      test_cu_lanes();
      test_random_cu();
      report_and_finish();
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/l1b_pkg.sv
hdl/l1b_ram.sv
hdl/l1b_ch.sv
hdl/l1b_ctrl.sv
hdl/l1b_bank.sv
bench/tb_clock.sv
bench/l1b_bank_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module l1b_bank_tb -o l1b_sim

# the simulation exits normally either way, the log decides
./obj_dir/l1b_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
